// File: list.f
+incdir+source
source/area_pkg.sv
source/pattern_gen.sv
source/bram_bank.sv
source/led_mixer.sv
source/area_top.sv
tests/area_props.sv
tests/area_checker.sv
tests/area_tb.sv

// File: source/area_defines.svh
/*
 * Sizes, seeds and step constants of the area demo data path.
 * Included by the package and by every module that needs a size or a constant.
 */
`ifndef AREA_DEFINES_SVH
`define AREA_DEFINES_SVH

// RAM bank geometry
// 32 banks of 256 x 16, one iCE40 block RAM each
`define AREA_NUM_BANKS 32
`define AREA_ADDR_W    8
`define AREA_WORD_W    16

// Number of 16x16 multipliers fed from bank pairs
`define AREA_NUM_PROD  18

// Pattern counter A
// Seed is its reset value, step is added on every run cycle
`define AREA_SEED_A    32'h1234_5678
`define AREA_STEP_A    32'h0001_2345

// Pattern counter B
// Different seed and step so that A ^ B keeps changing bit patterns
`define AREA_SEED_B    32'h8765_4321
`define AREA_STEP_B    32'h0005_4321

`endif

// File: source/area_pkg.sv
/*
 * Shared types of the area demo.
 * Modules pick them up by a wildcard import in their header.
 */
`default_nettype none

`include "area_defines.svh"

package area_pkg;

    // One RAM word
    typedef logic [`AREA_WORD_W-1:0] word_t;

    // One multiplier result, full width of a 16x16 product
    typedef logic [2*`AREA_WORD_W-1:0] product_t;

    // Request from the pattern producer to the RAM bank
    // Every bank sees the same address, only its wmask bit differs
    typedef struct packed {
        // Step taken this cycle
        logic                      valid;
        // Shared address for all banks
        logic [`AREA_ADDR_W-1:0]   addr;
        // Low half of counter A ^ counter B
        word_t                     wdata_base;
        // Full counter A ^ counter B, bit k enables bank k
        logic [`AREA_NUM_BANKS-1:0] wmask;
    } bank_req_t;

    // Registered read return of all banks
    typedef struct packed {
        // Fresh data, one cycle after a valid request
        logic                              valid;
        // Word of bank k sits at data[k]
        word_t [`AREA_NUM_BANKS-1:0]       data;
    } bank_rd_t;

endpackage : area_pkg

`default_nettype wire

// File: source/area_top.sv
/*
 * Top of the area demo.
 * Pattern producer feeds the RAM bank, the RAM bank feeds the LED mixer.
 * run freezes the whole chain, LEDs settle three edges after it drops.
 */
`default_nettype none

module area_top
    import area_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       run,
    output logic [7:0] led
);

    // Producer to RAM bank
    bank_req_t req;

    // RAM bank to LED mixer
    bank_rd_t  rd;

    // Counters and shared address
    pattern_gen u_pattern_gen (
        .CLK   (CLK),
        .rst_n (rst_n),
        .run   (run),
        .req   (req)
    );

    // 32 block RAMs, read-first
    bram_bank u_bram_bank (
        .CLK   (CLK),
        .rst_n (rst_n),
        .req   (req),
        .rd    (rd)
    );

    // Products, folds, rotators and LEDs
    led_mixer u_led_mixer (
        .CLK   (CLK),
        .rst_n (rst_n),
        .rd    (rd),
        .led   (led)
    );

endmodule : area_top

`default_nettype wire

// File: source/bram_bank.sv
/*
 * Bank of 32 read-first RAMs of 256 x 16 with registered read data.
 * A valid request writes the masked banks and returns the old words next cycle.
 */
`default_nettype none

`include "area_defines.svh"

module bram_bank
    import area_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  bank_req_t req,
    output bank_rd_t  rd
);

    localparam int unsigned RAM_DEPTH = 2 ** `AREA_ADDR_W;

    // Read data of every bank, no reset on payload
    word_t rd_word [`AREA_NUM_BANKS];
    logic  rd_valid;

    // Read return follows the request by one cycle
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.valid;
        end
    end

    for (genvar k = 0; k < `AREA_NUM_BANKS; k++) begin : g_bank
        // Zero contents come from the FPGA configuration
        word_t mem [RAM_DEPTH] = '{default: '0};
        word_t wdata;

        // Bank index mixed into the low five bits
        assign wdata = req.wdata_base ^ word_t'(k);

        // Read-first, the old word leaves while the new one goes in
        always_ff @(posedge CLK) begin
            if (req.valid) begin
                if (req.wmask[k]) begin
                    mem[req.addr] <= wdata;
                end
                rd_word[k] <= mem[req.addr];
            end
        end
    end

    // Gather the bank outputs into the read-return struct
    always_comb begin
        rd.valid = rd_valid;
        for (int k = 0; k < `AREA_NUM_BANKS; k++) begin
            rd.data[k] = rd_word[k];
        end
    end

endmodule : bram_bank

`default_nettype wire

// File: source/led_mixer.sv
/*
 * LED consumer. Multiplies fixed bank pairs, folds banks and products by XOR,
 * rotates the bank fold into a 16-bit register and drives the eight LEDs.
 * Everything advances only on cycles with fresh read data.
 */
`default_nettype none

`include "area_defines.svh"

module led_mixer
    import area_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  bank_rd_t   rd,
    output logic [7:0] led
);

    // 18 products of bank pairs
    product_t prod [`AREA_NUM_PROD];

    // XOR folds of banks and products
    word_t    bank_fold;
    product_t mult_fold;
    word_t    mult_lo;

    // Bank rotator, bit selector and the registered product bits
    word_t      bank_rot;
    logic [3:0] sel;
    logic [3:0] pick;
    logic [3:0] led_lo;

    // Group 1, banks i and i+8
    for (genvar i = 0; i < 8; i++) begin : g_mul_a
        assign prod[i] = product_t'(rd.data[i]) * product_t'(rd.data[i+8]);
    end

    // Group 2, banks 16+i and 20+i
    for (genvar i = 0; i < 4; i++) begin : g_mul_b
        assign prod[8+i] = product_t'(rd.data[16+i]) * product_t'(rd.data[20+i]);
    end

    // Group 3, banks 24+i and 28+i
    for (genvar i = 0; i < 4; i++) begin : g_mul_c
        assign prod[12+i] = product_t'(rd.data[24+i]) * product_t'(rd.data[28+i]);
    end

    // Group 4, banks i and 30+i
    for (genvar i = 0; i < 2; i++) begin : g_mul_d
        assign prod[16+i] = product_t'(rd.data[i]) * product_t'(rd.data[30+i]);
    end

    // Fold all bank words into one
    always_comb begin
        bank_fold = '0;
        for (int k = 0; k < `AREA_NUM_BANKS; k++) begin
            bank_fold ^= rd.data[k];
        end
    end

    // Fold all products into one
    always_comb begin
        mult_fold = '0;
        for (int j = 0; j < `AREA_NUM_PROD; j++) begin
            mult_fold ^= prod[j];
        end
    end

    assign mult_lo = mult_fold[`AREA_WORD_W-1:0];

    // Four product bits spaced by 4, 4-bit index wraps modulo 16
    always_comb begin
        pick[0] = mult_lo[sel];
        pick[1] = mult_lo[sel + 4'd4];
        pick[2] = mult_lo[sel + 4'd8];
        pick[3] = mult_lo[sel + 4'd12];
    end

    // Single register stage, frozen while rd.valid is low
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            bank_rot <= '0;
            sel      <= '0;
            led_lo   <= '0;
        end else if (rd.valid) begin
            // Rotate left by one, then mix in the fold
            bank_rot <= {bank_rot[`AREA_WORD_W-2:0], bank_rot[`AREA_WORD_W-1]} ^ bank_fold;
            // Bits picked with the selector before its increment
            led_lo   <= pick;
            sel      <= sel + 1'b1;
        end
    end

    // Top nibble of the bank rotator on the upper LEDs
    assign led = {bank_rot[`AREA_WORD_W-1 -: 4], led_lo};

endmodule : led_mixer

`default_nettype wire

// File: source/pattern_gen.sv
/*
 * Pattern producer. Holds the two pattern counters and the shared RAM address,
 * and registers one bank request per cycle in which run is high.
 */
`default_nettype none

`include "area_defines.svh"

module pattern_gen
    import area_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      run,
    output bank_req_t req
);

    // Pattern counters and the shared address
    logic [31:0]             cnt_a;
    logic [31:0]             cnt_b;
    logic [`AREA_ADDR_W-1:0] addr;

    // Mix of both counters, source of write enables and write data
    logic [31:0]             mix;

    // Registered request fields
    logic                      req_valid;
    logic [`AREA_ADDR_W-1:0]   req_addr;
    word_t                     req_wdata;
    logic [`AREA_NUM_BANKS-1:0] req_wmask;

    assign mix = cnt_a ^ cnt_b;

    // Counters advance only while run is high, so a low run freezes the pattern
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt_a     <= `AREA_SEED_A;
            cnt_b     <= `AREA_SEED_B;
            addr      <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= run;
            if (run) begin
                cnt_a <= cnt_a + `AREA_STEP_A;
                cnt_b <= cnt_b + `AREA_STEP_B;
                // Wraps at 256, one pass over the banks
                addr  <= addr + 1'b1;
            end
        end
    end

    // Payload taken from the values before the advance
    // Holds while run is low
    always_ff @(posedge CLK) begin
        if (run) begin
            req_addr  <= addr;
            req_wdata <= mix[`AREA_WORD_W-1:0];
            req_wmask <= mix;
        end
    end

    assign req = '{valid: req_valid, addr: req_addr, wdata_base: req_wdata, wmask: req_wmask};

endmodule : pattern_gen

`default_nettype wire

// File: tests/area_checker.sv
/*
 * Reference model and scoreboard of the area demo.
 * Follows run and the reset through counters, RAM contents, folds and rotator,
 * compares the LEDs on every rising edge and watches held segments.
 */
`default_nettype none

`include "area_defines.svh"

module area_checker
    import area_pkg::*;
(
    input logic       CLK,
    input logic       rst_n,
    input logic       run,
    input logic       hold_chk,
    input logic [7:0] led
);

    localparam int RAM_DEPTH = 2 ** `AREA_ADDR_W;

    // Counters read by the testbench at the end
    int unsigned led_errors    = 0;
    int unsigned hold_errors   = 0;
    int unsigned compare_count = 0;

    // Producer state
    logic [31:0]             m_cnt_a;
    logic [31:0]             m_cnt_b;
    logic [`AREA_ADDR_W-1:0] m_addr;
    bank_req_t               m_req;

    // RAM contents and the registered read return
    word_t    m_mem [`AREA_NUM_BANKS][RAM_DEPTH];
    bank_rd_t m_rd;

    // LED stage
    word_t      m_bank_rot;
    logic [3:0] m_sel;
    logic [3:0] m_led_lo;

    // Held segment tracking
    int unsigned hold_edges;
    logic [7:0]  held_led;

    // Zero contents as after FPGA configuration
    initial begin
        int k;
        int a;
        for (k = 0; k < `AREA_NUM_BANKS; k++) begin
            for (a = 0; a < RAM_DEPTH; a++) begin
                m_mem[k][a] = '0;
            end
        end
    end

    // Left bank of product j
    function automatic int first_bank(input int j);
        if (j < 8) return j;
        else if (j < 12) return 16 + (j - 8);
        else if (j < 16) return 24 + (j - 12);
        else return j - 16;
    endfunction

    // Right bank of product j
    function automatic int second_bank(input int j);
        if (j < 8) return j + 8;
        else if (j < 12) return 20 + (j - 8);
        else if (j < 16) return 28 + (j - 12);
        else return 30 + (j - 16);
    endfunction

    task automatic reset_model();
        m_cnt_a    = `AREA_SEED_A;
        m_cnt_b    = `AREA_SEED_B;
        m_addr     = '0;
        m_req      = '0;
        m_rd       = '0;
        m_bank_rot = '0;
        m_sel      = '0;
        m_led_lo   = '0;
        hold_edges = 0;
    endtask

    // One rising edge, later stages first so each sees the old values
    task automatic advance_model(input logic run_now);
        word_t       bank_fold;
        logic [31:0] mult_fold;
        logic [31:0] mix;
        int          k;
        int          pos;

        // LED stage, fed by the read return of the previous edge
        if (m_rd.valid) begin
            bank_fold = '0;
            mult_fold = '0;
            for (k = 0; k < `AREA_NUM_BANKS; k++) begin
                bank_fold ^= m_rd.data[k];
            end
            for (k = 0; k < `AREA_NUM_PROD; k++) begin
                mult_fold ^= 32'(m_rd.data[first_bank(k)]) * 32'(m_rd.data[second_bank(k)]);
            end
            m_bank_rot = {m_bank_rot[14:0], m_bank_rot[15]} ^ bank_fold;
            // led[b] takes fold bit sel + 4b, wrapped at 16
            for (k = 0; k < 4; k++) begin
                pos = (int'(m_sel) + 4 * k) % 16;
                m_led_lo[k] = mult_fold[pos];
            end
            m_sel = m_sel + 4'd1;
        end

        // RAM stage, old word out before the new one lands
        m_rd.valid = m_req.valid;
        if (m_req.valid) begin
            for (k = 0; k < `AREA_NUM_BANKS; k++) begin
                m_rd.data[k] = m_mem[k][m_req.addr];
                if (m_req.wmask[k]) begin
                    m_mem[k][m_req.addr] = m_req.wdata_base ^ word_t'(k);
                end
            end
        end

        // Producer, frozen while run is low
        m_req.valid = run_now;
        if (run_now) begin
            mix              = m_cnt_a ^ m_cnt_b;
            m_req.addr       = m_addr;
            m_req.wdata_base = mix[15:0];
            m_req.wmask      = mix;
            m_cnt_a          = m_cnt_a + `AREA_STEP_A;
            m_cnt_b          = m_cnt_b + `AREA_STEP_B;
            m_addr           = m_addr + 1'b1;
        end
    endtask

    // led still holds the value from the previous edge here
    task automatic compare_led();
        logic [7:0] expected;
        expected = {m_bank_rot[15:12], m_led_lo};
        compare_count++;
        if (led !== expected) begin
            led_errors++;
            $display("[FAIL] t=%0t led expected %02h actual %02h", $time, expected, led);
        end
    endtask

    // Frozen from the fourth edge of a low segment on
    task automatic check_hold();
        if (hold_chk && !run) begin
            hold_edges++;
            if (hold_edges == 4) begin
                held_led = led;
            end else if (hold_edges > 4 && led !== held_led) begin
                hold_errors++;
                $display("[FAIL] t=%0t led expected %02h (held) actual %02h",
                         $time, held_led, led);
            end
        end else begin
            hold_edges = 0;
        end
    endtask

    always @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            compare_led();
            check_hold();
            advance_model(run);
        end
    end

endmodule : area_checker

`default_nettype wire

// File: tests/area_props.sv
/*
 * Concurrent checks on the RAM bank request and read return.
 * Bound into bram_bank, a failed check raises $error and bumps fail_count.
 */
`default_nettype none

module area_props
    import area_pkg::*;
(
    input logic      CLK,
    input logic      rst_n,
    input bank_req_t req,
    input bank_rd_t  rd
);

    // Failed checks, summed into the closing line
    int unsigned fail_count = 0;

    // Read return trails the request by one edge
    a_valid_follows: assert property (
        @(posedge CLK) disable iff (!rst_n)
        rd.valid == $past(req.valid)
    ) else begin
        fail_count++;
        $error("rd.valid does not follow req.valid of the previous edge");
    end

    // Stale return keeps its words
    // Only once the banks have delivered known data
    a_data_held: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (!rd.valid && !$isunknown($past(rd.data))) |-> $stable(rd.data)
    ) else begin
        fail_count++;
        $error("rd.data changed while rd.valid was low");
    end

    // Both valid flags known out of reset
    a_valid_known: assert property (
        @(posedge CLK) disable iff (!rst_n)
        !$isunknown({req.valid, rd.valid})
    ) else begin
        fail_count++;
        $error("req.valid or rd.valid is unknown after reset");
    end

endmodule : area_props

bind bram_bank area_props u_area_props (
    .CLK   (CLK),
    .rst_n (rst_n),
    .req   (req),
    .rd    (rd)
);

`default_nettype wire

// File: tests/area_tb.sv
/*
 * Testbench of the area demo.
 * Plays run segments from tests/area_testdata.txt after a 16-cycle reset,
 * lets area_checker compare the LEDs and prints the closing summary.
 */
`default_nettype none

module area_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int MAX_SEG       = 32;
    localparam int RESET_CYCLES  = 16;
    localparam int JITTER_MAX    = 3;
    localparam int TAIL_CYCLES   = 8;
    localparam int MARGIN_CYCLES = 64;

    // DUT ports
    logic       CLK;
    logic       rst_n;
    logic       run;
    logic [7:0] led;

    // Hold-expect flag of the current segment, for the checker
    logic hold_chk;

    // Three words per segment: run, cycle count, hold flag
    logic [15:0] seg_words [3*MAX_SEG];
    int unsigned num_seg;
    int unsigned tb_errors;
    time         wd_limit;
    logic        wd_armed;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    area_top u_area_top (
        .CLK   (CLK),
        .rst_n (rst_n),
        .run   (run),
        .led   (led)
    );

    area_checker u_checker (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .run      (run),
        .hold_chk (hold_chk),
        .led      (led)
    );

    // Segments end at the first run word the file did not fill
    function automatic int unsigned count_segments();
        int unsigned n;
        n = 0;
        while (n < MAX_SEG && seg_words[3*n] <= 16'd1) begin
            n++;
        end
        return n;
    endfunction

    // Whole run with every segment at its longest, plus margin
    function automatic time run_limit();
        time         cycles;
        int unsigned s;
        cycles = RESET_CYCLES + TAIL_CYCLES + MARGIN_CYCLES;
        for (s = 0; s < num_seg; s++) begin
            cycles += seg_words[3*s+1] + JITTER_MAX;
        end
        return cycles * CLK_PERIOD;
    endfunction

    // Called on a falling edge, returns on the falling edge that ends the segment
    task automatic play_segment(input int unsigned idx);
        int unsigned len;
        len      = seg_words[3*idx+1] + ($urandom % (JITTER_MAX + 1));
        run      = seg_words[3*idx][0];
        hold_chk = seg_words[3*idx+2][0];
        repeat (len) @(negedge CLK);
    endtask

    // Watchdog
    initial begin
        wait (wd_armed === 1'b1);
        #(wd_limit);
        $display("Watchdog expired after %0t time units, the run did not finish", wd_limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int unsigned seg;
        int unsigned total;
        int unsigned i;
        CLK       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        hold_chk  = 1'b0;
        tb_errors = 0;
        wd_armed  = 1'b0;
        wd_limit  = 0;
        void'($urandom(32'h6fda_02f7));

        // Unused entries keep a run word that no segment can have
        for (i = 0; i < 3*MAX_SEG; i++) begin
            seg_words[i] = '1;
        end
        $readmemh("tests/area_testdata.txt", seg_words);
        num_seg = count_segments();
        if (num_seg == 0) begin
            tb_errors++;
            $display("No run segments could be read from tests/area_testdata.txt");
        end
        wd_limit = run_limit();
        wd_armed = 1'b1;

        repeat (RESET_CYCLES) @(negedge CLK);
        rst_n = 1'b1;

        for (seg = 0; seg < num_seg; seg++) begin
            play_segment(seg);
        end

        // Let the last step drain to the LEDs
        run      = 1'b0;
        hold_chk = 1'b0;
        repeat (TAIL_CYCLES) @(negedge CLK);

        if (u_checker.compare_count == 0) begin
            tb_errors++;
            $display("The checker never compared the LEDs");
        end

        total = u_checker.led_errors + u_checker.hold_errors
              + u_area_top.u_bram_bank.u_area_props.fail_count + tb_errors;
        $display("Error counts: led %0d, hold %0d, assertions %0d, testbench %0d",
                 u_checker.led_errors, u_checker.hold_errors,
                 u_area_top.u_bram_bank.u_area_props.fail_count, tb_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : area_tb

`default_nettype wire

// File: tests/area_testdata.txt
// Run segments for the area demo testbench, one per line, values in hex
// Columns: run level, cycle count, hold-expect flag (LEDs frozen from the fourth edge)
// Idle after reset, LEDs stay at zero
0 0014 1
// Long run, more than two passes over the 256 addresses
1 028c 0
0 0010 1
1 0040 0
0 0008 1
// Short bursts around pauses
1 0003 0
0 0005 1
1 0001 0
0 0006 0
1 0002 0
0 0009 1
// Resume for another pass
1 0120 0
0 000c 1
